// File: traceFramePkg.sv
// trace frame package: stream word width, frame word offsets and reply layout
package traceFramePkg;

  ////////////////////////////////////////
  // stream words
  ////////////////////////////////////////

  localparam int wordWidth = 32;      // bits per stream word
  localparam int rxCountWidth = 10;   // receive word counter

  ////////////////////////////////////////
  // positions in the received frame
  ////////////////////////////////////////

  localparam int headerWords = 4;     // echoed as-is, positions 0 to 3
  localparam int seqOffset = 4;       // sequence low, high follows
  localparam int minstretOffset = 9;  // retired count low, high follows

  // where those words land in the capture store
  localparam int storedWords = 8;
  localparam int seqSlot = headerWords;
  localparam int minstretSlot = headerWords + 2;
  localparam int slotIndexWidth = $clog2(storedWords);

  ////////////////////////////////////////
  // reply layout
  ////////////////////////////////////////

  // stored words in order, then the host load word
  localparam int replyWords = 9;
  localparam int beatWidth = $clog2(replyWords);

  // capture FSM encoding
  localparam logic [1:0] capIdle = 2'd0;
  localparam logic [1:0] capCapture = 2'd1;
  localparam logic [1:0] capCaptureDone = 2'd2;   // frameDone cycle
  localparam logic [1:0] capDone = 2'd3;

endpackage

// File: hostLinkPkg.sv
// host link package: loss emulation, host load word and reply FSM encoding
package hostLinkPkg;

  ////////////////////////////////////////
  // host behavior
  ////////////////////////////////////////

  // replies sent before one is dropped
  localparam int lossInterval = 10;
  localparam int lossCountWidth = 8;

  // stand-in for the host load estimate, last reply word
  localparam int hostLoadWord = 1;

  ////////////////////////////////////////
  // reply FSM encoding
  ////////////////////////////////////////

  localparam logic [1:0] sndReady = 2'd0;      // idle, waiting for frameDone
  localparam logic [1:0] sndTransmit = 2'd1;   // txValid high
  localparam logic [1:0] sndWaitSend = 2'd2;   // suppressed reply
  localparam logic [1:0] sndFinished = 2'd3;   // loss count advances

endpackage

// File: frameCapture.sv
// frame capture: receives a trace frame and keeps the words the reply needs
`timescale 1ns/10ps

module frameCapture (
  input  logic clk,
  input  logic reset,
  input  logic [traceFramePkg::wordWidth-1:0] rxData,
  input  logic rxValid,
  input  logic rxLast,
  output logic frameDone,
  output logic [traceFramePkg::storedWords*traceFramePkg::wordWidth-1:0] capturedWords
);

  import traceFramePkg::*;

  logic [1:0] capState;
  logic [1:0] capNext;
  logic [1:0] startNext;
  logic [rxCountWidth-1:0] rxCount;
  logic [rxCountWidth-1:0] wordPos;
  logic firstWord;
  logic slotHit;
  logic [slotIndexWidth-1:0] slotIdx;
  logic [wordWidth-1:0] store [storedWords];

  ////////////////////////////////////////
  // receive FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) capState <= capIdle;
    else capState <= capNext;
  end

  // a one-word frame goes straight to captureDone
  assign startNext = rxLast ? capCaptureDone : capCapture;

  always_comb begin
    case (capState)
      capIdle: begin
        if (rxValid) capNext = startNext;
        else capNext = capIdle;
      end
      capCapture: begin
        if (rxValid && rxLast) capNext = capCaptureDone;
        else capNext = capCapture;
      end
      capCaptureDone: begin
        // next frame may begin right away, the receiver never stalls
        if (rxValid) capNext = startNext;
        else capNext = capDone;
      end
      capDone: begin
        if (rxValid) capNext = startNext;
        else capNext = capIdle;
      end
      default: capNext = capIdle;
    endcase
  end

  assign frameDone = capState == capCaptureDone;

  ////////////////////////////////////////
  // word counter
  ////////////////////////////////////////

  // any word seen outside capture opens a new frame
  assign firstWord = capState != capCapture;
  assign wordPos = firstWord ? '0 : rxCount;

  always_ff @(posedge clk) begin
    if (reset) begin
      rxCount <= '0;
    end else if (rxValid) begin
      if (firstWord) rxCount <= rxCountWidth'(1);
      else if (rxCount != '1) rxCount <= rxCount + 1'b1;   // saturate on huge frames
    end
  end

  ////////////////////////////////////////
  // word store
  ////////////////////////////////////////

  // stream position to store slot
  always_comb begin
    slotHit = 1'b0;
    slotIdx = '0;
    if (wordPos < rxCountWidth'(headerWords)) begin
      slotHit = 1'b1;
      slotIdx = slotIndexWidth'(wordPos);
    end else if (wordPos == rxCountWidth'(seqOffset) ||
                 wordPos == rxCountWidth'(seqOffset + 1)) begin
      slotHit = 1'b1;
      slotIdx = slotIndexWidth'(wordPos - rxCountWidth'(seqOffset) + rxCountWidth'(seqSlot));
    end else if (wordPos == rxCountWidth'(minstretOffset) ||
                 wordPos == rxCountWidth'(minstretOffset + 1)) begin
      slotHit = 1'b1;
      slotIdx = slotIndexWidth'(wordPos - rxCountWidth'(minstretOffset) +
                                rxCountWidth'(minstretSlot));
    end
  end

  always_ff @(posedge clk) begin
    if (rxValid) begin
      // short frames leave the words they lack at zero
      if (firstWord) begin
        for (int k = 0; k < storedWords; k++) begin
          store[k] <= '0;
        end
      end
      if (slotHit) store[slotIdx] <= rxData;   // wins over the clear
    end
  end

  always_comb begin
    for (int k = 0; k < storedWords; k++) begin
      capturedWords[k*wordWidth +: wordWidth] = store[k];
    end
  end

endmodule

// File: replySender.sv
// reply sender: builds the nine-word acknowledge and drops every eleventh one
`timescale 1ns/10ps

module replySender (
  input  logic clk,
  input  logic reset,
  input  logic frameDone,
  input  logic [traceFramePkg::storedWords*traceFramePkg::wordWidth-1:0] capturedWords,
  output logic [traceFramePkg::wordWidth-1:0] txData,
  output logic txValid,
  output logic txLast,
  input  logic txReady
);

  import traceFramePkg::*;
  import hostLinkPkg::*;

  logic [1:0] sndState;
  logic [1:0] sndNext;
  logic [beatWidth-1:0] beat;
  logic lastBeat;
  logic accepted;
  logic dropReply;
  logic takeFrame;
  logic [lossCountWidth-1:0] lossCount;
  logic [wordWidth-1:0] replyStore [storedWords];

  assign takeFrame = frameDone && sndState == sndReady;   // busy sender ignores it
  assign dropReply = lossCount == lossCountWidth'(lossInterval);
  assign accepted = txValid && txReady;
  assign lastBeat = beat == beatWidth'(replyWords - 1);

  ////////////////////////////////////////
  // reply FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) sndState <= sndReady;
    else sndState <= sndNext;
  end

  always_comb begin
    case (sndState)
      sndReady: begin
        if (takeFrame && dropReply) sndNext = sndWaitSend;
        else if (takeFrame) sndNext = sndTransmit;
        else sndNext = sndReady;
      end
      sndTransmit: begin
        if (accepted && lastBeat) sndNext = sndFinished;
        else sndNext = sndTransmit;
      end
      sndWaitSend: sndNext = sndFinished;   // one cycle, nothing on the wire
      sndFinished: sndNext = sndReady;
      default: sndNext = sndReady;
    endcase
  end

  ////////////////////////////////////////
  // beat counter and word mux
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      beat <= '0;
    end else if (sndState == sndReady) begin
      beat <= '0;
    end else if (accepted && !lastBeat) begin
      beat <= beat + 1'b1;   // only moves on an accepted word
    end
  end

  // private copy so the next frame can arrive during the reply
  always_ff @(posedge clk) begin
    if (takeFrame) begin
      for (int k = 0; k < storedWords; k++) begin
        replyStore[k] <= capturedWords[k*wordWidth +: wordWidth];
      end
    end
  end

  always_comb begin
    if (beat < beatWidth'(storedWords)) txData = replyStore[slotIndexWidth'(beat)];
    else txData = wordWidth'(hostLoadWord);   // host load goes last
  end

  assign txValid = sndState == sndTransmit;
  assign txLast = txValid && lastBeat;

  ////////////////////////////////////////
  // frame loss emulation
  ////////////////////////////////////////

  // counts finished replies, sent or dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      lossCount <= '0;
    end else if (sndState == sndFinished) begin
      if (dropReply) lossCount <= '0;   // wrap after lossInterval + 1
      else lossCount <= lossCount + 1'b1;
    end
  end

endmodule

// File: traceHostTop.sv
// trace host top: frame capture feeding the acknowledge reply sender
`timescale 1ns/10ps

module traceHostTop (
  input  logic clk,
  input  logic reset,
  input  logic [traceFramePkg::wordWidth-1:0] rxData,
  input  logic rxValid,
  input  logic rxLast,
  output logic [traceFramePkg::wordWidth-1:0] txData,
  output logic txValid,
  output logic txLast,
  input  logic txReady
);

  import traceFramePkg::*;

  logic frameDone;                                    // one-cycle pulse
  logic [storedWords*wordWidth-1:0] capturedWords;    // held until next frame starts

  frameCapture i_capture (
    .clk,
    .reset,
    .rxData,
    .rxValid,
    .rxLast,
    .frameDone,
    .capturedWords
  );

  // first reply word two cycles after the last received word
  replySender i_sender (
    .clk,
    .reset,
    .frameDone,
    .capturedWords,
    .txData,
    .txValid,
    .txLast,
    .txReady
  );

endmodule

// File: tbReplyChecker.sv
// reply checker comparing the transmit stream with a reference acknowledge model
`timescale 1ns/10ps

module tbReplyChecker (
  input logic clk,
  input logic reset,
  input logic rxValid,
  input logic rxLast,
  input logic [traceFramePkg::wordWidth-1:0] txData,
  input logic txValid,
  input logic txLast,
  input logic txReady
);

  import traceFramePkg::*;
  import hostLinkPkg::*;

  localparam int maxFrameWords = 40;

  logic [wordWidth-1:0] frameBuf [maxFrameWords];
  logic [wordWidth-1:0] expectQ [$];
  logic [wordWidth-1:0] expWord;
  logic [wordWidth-1:0] prevData;
  logic prevLast;
  logic prevValid;
  logic prevStall;
  int frameCount = 0;
  int wordsChecked = 0;
  int mismatchCount = 0;
  int otherErrors = 0;
  int beatIdx = 0;
  int cycle = 0;
  int lastRxCycle = 0;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // header 0..3, sequence 4..5, retired count 9..10, then host load
  function automatic logic [replyWords*wordWidth-1:0] refReply(input int len);
    logic [replyWords*wordWidth-1:0] reply;
    int srcPos;
    reply = '0;
    for (int k = 0; k < replyWords - 1; k++) begin
      srcPos = (k < 6) ? k : k + 3;
      if (srcPos < len) reply[k*wordWidth +: wordWidth] = frameBuf[srcPos];   // else zero
    end
    reply[(replyWords-1)*wordWidth +: wordWidth] = wordWidth'(hostLoadWord);
    return reply;
  endfunction

  function automatic bit replyDropped(input int number);
    return number >= 1 && (number % (lossInterval + 1)) == 0;
  endfunction

  task automatic storeFrameWord(input int pos, input logic [wordWidth-1:0] word);
    if (pos < maxFrameWords) frameBuf[pos] = word;
  endtask

  task automatic expectReply(input int number, input int len);
    logic [replyWords*wordWidth-1:0] reply;
    frameCount++;
    if (!replyDropped(number)) begin
      reply = refReply(len);
      for (int k = 0; k < replyWords; k++) expectQ.push_back(reply[k*wordWidth +: wordWidth]);
    end
  endtask

  task automatic showMismatch(input string name, input logic [wordWidth-1:0] got,
                              input logic [wordWidth-1:0] exp);
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    mismatchCount++;
  endtask

  task automatic failCheck(input string what);
    $display("ERROR at %0t: %s", $time, what);
    otherErrors++;
  endtask

  function automatic int totalErrors();
    return mismatchCount + otherErrors + expectQ.size();
  endfunction

  task automatic printSummary();
    $display("summary: %0d frames, %0d words, %0d mismatches, %0d other errors, %0d unsent",
             frameCount, wordsChecked, mismatchCount, otherErrors, expectQ.size());
  endtask

  ////////////////////////////////////////
  // stream monitor
  ////////////////////////////////////////

  // sampled at negedge since a transfer happens at the following rising edge
  always @(negedge clk) begin
    if (!reset) begin
      cycle++;
      if (rxValid && rxLast) lastRxCycle = cycle;
      if (txLast && !txValid) failCheck("txLast high without txValid");
      if (frameCount == 0 && txValid) failCheck("txValid high before any frame was sent");
      if (prevStall) begin
        if (!txValid) failCheck("txValid dropped while the sink was stalling");
        if (txData !== prevData) showMismatch("txData (held)", txData, prevData);
        if (txLast !== prevLast)
          showMismatch("txLast (held)", wordWidth'(txLast), wordWidth'(prevLast));
      end
      if (txValid && !prevValid && cycle - lastRxCycle != 2)
        failCheck($sformatf("first reply word %0d cycles after last frame word, not 2",
                            cycle - lastRxCycle));
      if (txValid && txReady) begin
        if (expectQ.size() == 0) begin
          failCheck("reply word accepted while no reply was expected");
        end else begin
          expWord = expectQ.pop_front();
          wordsChecked++;
          if (txData !== expWord) showMismatch("txData", txData, expWord);
          if (txLast !== (beatIdx == replyWords - 1))
            showMismatch("txLast", wordWidth'(txLast), wordWidth'(beatIdx == replyWords - 1));
          beatIdx = (beatIdx == replyWords - 1) ? 0 : beatIdx + 1;
        end
      end
      prevStall = txValid && !txReady;
      prevValid = txValid;
      prevData = txData;
      prevLast = txLast;
    end else begin
      prevStall = 1'b0;
      prevValid = 1'b0;
    end
  end

endmodule

// File: tbTraceHost.sv
// trace host testbench driving random trace frames under random back-pressure
`timescale 1ns/10ps

module tbTraceHost;

  import traceFramePkg::*;

  localparam int replyTimeout = 300;   // cycles allowed per reply
  localparam int dropIdleCycles = 4;   // gap after a suppressed frame
  localparam int totalFrames = 25;

  logic clk;
  logic reset;
  logic [wordWidth-1:0] rxData;
  logic rxValid;
  logic rxLast;
  logic [wordWidth-1:0] txData;
  logic txValid;
  logic txLast;
  logic txReady;

  integer seed;
  bit backPressure;
  bit timedOut;
  int frameNum;

  traceHostTop i_dut (
    .clk,
    .reset,
    .rxData,
    .rxValid,
    .rxLast,
    .txData,
    .txValid,
    .txLast,
    .txReady
  );

  tbReplyChecker i_checker (
    .clk,
    .reset,
    .rxValid,
    .rxLast,
    .txData,
    .txValid,
    .txLast,
    .txReady
  );

  always #2 clk = ~clk;   // 4 ns period

  // steps to just after the next rising edge and picks a new txReady
  task automatic nextCycle();
    logic [31:0] rnd;
    @(posedge clk);
    #1;
    rnd = $random(seed);
    if (backPressure) txReady = rnd[0];
    else txReady = 1'b1;
  endtask

  function automatic int randomLength();
    logic [31:0] rnd;
    rnd = $random(seed);
    return 11 + int'(rnd % 30);   // 11 to 40 words
  endfunction

  // waits for the accepted txLast of the current reply
  task automatic awaitReply();
    int cycles;
    bit seen;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < replyTimeout) begin
      @(negedge clk);
      if (txValid && txReady && txLast) seen = 1'b1;
      nextCycle();
      cycles++;
    end
    if (!seen) begin
      i_checker.failCheck($sformatf("frame %0d: no reply seen within timeout", frameNum));
      timedOut = 1'b1;   // no further frames
    end
  endtask

  task automatic sendFrame(input int len);
    frameNum++;
    for (int i = 0; i < len; i++) begin
      nextCycle();
      rxData = $random(seed);
      rxValid = 1'b1;
      rxLast = (i == len - 1);
      i_checker.storeFrameWord(i, rxData);
    end
    nextCycle();   // this is the frameDone cycle
    rxData = '0;
    rxValid = 1'b0;
    rxLast = 1'b0;
    i_checker.expectReply(frameNum, len);
    if (i_checker.replyDropped(frameNum)) repeat (dropIdleCycles) nextCycle();
    else awaitReply();
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    seed = 32'h45a89dc3;
    clk = 1'b0;
    reset = 1'b1;
    rxData = '0;
    rxValid = 1'b0;
    rxLast = 1'b0;
    txReady = 1'b1;
    backPressure = 1'b0;
    timedOut = 1'b0;
    frameNum = 0;
    repeat (2) nextCycle();
    reset = 1'b0;

    repeat (10) nextCycle();   // quiet link before the first frame
    for (int n = 0; n < 3 && !timedOut; n++) sendFrame(randomLength());
    if (!timedOut) sendFrame(6);   // short frame without the retired count

    backPressure = 1'b1;
    while (frameNum < totalFrames && !timedOut) sendFrame(randomLength());
    backPressure = 1'b0;
    repeat (20) nextCycle();   // catch late or stray reply words

    i_checker.printSummary();
    if (i_checker.totalErrors() == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

endmodule

// File: list.f
traceFramePkg.sv
hostLinkPkg.sv
frameCapture.sv
replySender.sv
traceHostTop.sv
tbReplyChecker.sv
tbTraceHost.sv

// File: Makefile
# Verilator build and run for the trace host testbench

VERILATOR ?= verilator
TOP       ?= tbTraceHost
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

PASS_TEXT := Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
